// ==== design/bootPkg.sv ====
package bootPkg;

    // Word address width of the on-chip program RAM
    localparam int RamAddrBits = 15;

    // Address bit that moves a bus access into I/O space
    localparam int ioSelectBit = 31;

    // LED patterns while the loader is busy
    localparam logic [7:0] ledResetting = 8'b0010_0100;
    localparam logic [7:0] ledCounting = 8'b0100_1001;
    localparam logic [7:0] ledLoading = 8'b1001_0010;

    // Processor request towards memory and I/O
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] writeData;
        logic read;
        logic write;
    } cpuBusReq;

    // Reply to the processor
    typedef struct packed {
        logic [31:0] readData;
        logic ready;
        logic written;
    } cpuBusRsp;

    // Single RAM port as seen by wordRam
    typedef struct packed {
        logic [RamAddrBits-1:0] address;
        logic [31:0] writeData;
        logic read;
        logic write;
    } ramReq;

    // One pixel store into the frame buffer
    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] color;
        logic write;
    } pixelWrite;

    typedef enum logic [3:0] {
        resetWait,
        readCount,
        waitCount,
        copyWord,
        finish,
        running,
        debug
    } loaderState;

endpackage

// ==== design/wordRam.sv ====
module wordRam #(
    parameter int Words = 2 ** 15
) (
    input  logic             RAMClock,
    input  bootPkg::ramReq   request,
    output logic [31:0]      readData,
    output logic             ready,
    output logic             written
);

    logic [31:0] memory [Words];

    // Same-cycle read returns the old word
    always_ff @(posedge RAMClock) begin
        if (request.write) begin
            memory[request.address] <= request.writeData;
        end
        if (request.read) begin
            readData <= memory[request.address];
        end
    end

    // Strobes follow the sampled request by one cycle
    always_ff @(posedge RAMClock) begin
        ready <= request.read;
        written <= request.write;
    end

endmodule

// ==== design/sdWordReader.sv ====
module sdWordReader (
    input  logic        RAMClock,
    input  logic        reset,
    input  logic        read,
    input  logic [31:0] address,
    output logic [31:0] data,
    output logic        busy,
    output logic        done,
    output logic        cs,
    output logic        mosi,
    output logic        sclk,
    input  logic        miso
);

    typedef enum logic [1:0] {
        idle,
        command,
        waitStart,
        receive
    } readerPhase;

    // Card command for a single word read
    typedef enum logic [7:0] {
        readSingle = 8'h51
    } sdOpcode;

    readerPhase phase;
    logic [31:0] shiftReg;
    logic [4:0] bitCount;

    // Shift register carries the command out and the word in
    assign data = shiftReg;

    // Line idles high outside the command
    assign mosi = (phase == command) ? shiftReg[31] : 1'b1;

    always_ff @(posedge RAMClock) begin
        if (reset) begin
            phase <= idle;
            busy <= 1'b0;
            done <= 1'b0;
            cs <= 1'b1;
            sclk <= 1'b0;
            bitCount <= '0;
        end else begin
            done <= 1'b0;
            case (phase)
                idle: begin
                    sclk <= 1'b0;
                    if (read) begin
                        shiftReg <= {readSingle, address[23:0]};
                        bitCount <= 5'd31;
                        busy <= 1'b1;
                        cs <= 1'b0;
                        phase <= command;
                    end
                end
                command: begin
                    sclk <= ~sclk;
                    // Next bit goes out on the falling clock edge
                    if (sclk) begin
                        shiftReg <= {shiftReg[30:0], 1'b1};
                        if (bitCount == 5'd0) begin
                            phase <= waitStart;
                        end else begin
                            bitCount <= bitCount - 1'b1;
                        end
                    end
                end
                waitStart: begin
                    sclk <= ~sclk;
                    if (!sclk && !miso) begin
                        bitCount <= 5'd31;
                        phase <= receive;
                    end
                end
                receive: begin
                    sclk <= ~sclk;
                    // Sample on the rising clock edge
                    if (!sclk) begin
                        shiftReg <= {shiftReg[30:0], miso};
                        if (bitCount == 5'd0) begin
                            busy <= 1'b0;
                            done <= 1'b1;
                            cs <= 1'b1;
                            sclk <= 1'b0;
                            phase <= idle;
                        end else begin
                            bitCount <= bitCount - 1'b1;
                        end
                    end
                end
                default: phase <= idle;
            endcase
        end
    end

endmodule

// ==== design/bootLoader.sv ====
module bootLoader #(
    parameter int ResetCycles = 1023
) (
    input  logic                                 RAMClock,
    input  logic                                 reset,
    input  logic [3:0]                           buttons,
    output logic                                 sdRead,
    output logic [31:0]                          sdAddress,
    input  logic [31:0]                          sdData,
    input  logic                                 sdBusy,
    input  logic                                 sdDone,
    output logic                                 loadWrite,
    output logic [bootPkg::RamAddrBits-1:0]      loadAddress,
    output logic [31:0]                          loadData,
    output bootPkg::loaderState                  state,
    output logic [bootPkg::RamAddrBits-1:0]      debugAddress,
    input  logic [31:0]                          ramData,
    input  bootPkg::pixelWrite                   cpuIoWrite,
    output logic                                 cpuReset,
    output logic [7:0]                           ledOut
);

    localparam int TimerBits = $clog2(ResetCycles + 1);

    logic [TimerBits-1:0] resetTimer;
    logic [31:0] wordsLeft;
    logic [1:0] byteIndex;
    logic [3:0] buttonsLast;
    logic [3:0] pressed;

    // Button order is debugEnter, run, next, prev from bit 0
    assign pressed = buttons & ~buttonsLast;

    // Processor only runs when the loader has handed over
    assign cpuReset = (state != bootPkg::running);

    always_ff @(posedge RAMClock) begin
        if (reset) begin
            state <= bootPkg::resetWait;
            resetTimer <= '0;
            wordsLeft <= '0;
            byteIndex <= '0;
            buttonsLast <= '0;
            sdRead <= 1'b0;
            sdAddress <= '0;
            loadWrite <= 1'b0;
            debugAddress <= '0;
            ledOut <= bootPkg::ledResetting;
        end else begin
            sdRead <= 1'b0;
            loadWrite <= 1'b0;
            buttonsLast <= buttons;
            case (state)
                bootPkg::resetWait: begin
                    ledOut <= bootPkg::ledResetting;
                    if (resetTimer == TimerBits'(ResetCycles - 1)) begin
                        state <= bootPkg::readCount;
                    end else begin
                        resetTimer <= resetTimer + 1'b1;
                    end
                end
                bootPkg::readCount: begin
                    ledOut <= bootPkg::ledCounting;
                    // Word 0 of the image holds the word count
                    if (!sdBusy) begin
                        sdAddress <= '0;
                        sdRead <= 1'b1;
                        state <= bootPkg::waitCount;
                    end
                end
                bootPkg::waitCount: begin
                    if (sdDone) begin
                        wordsLeft <= sdData;
                        if (sdData == 32'd0) begin
                            state <= bootPkg::finish;
                        end else begin
                            sdAddress <= 32'd1;
                            sdRead <= 1'b1;
                            state <= bootPkg::copyWord;
                        end
                    end
                end
                bootPkg::copyWord: begin
                    ledOut <= bootPkg::ledLoading;
                    if (sdDone) begin
                        // Card word k lands in RAM word k-1
                        loadWrite <= 1'b1;
                        loadAddress <= sdAddress[bootPkg::RamAddrBits-1:0] - 1'b1;
                        loadData <= sdData;
                        wordsLeft <= wordsLeft - 1'b1;
                        if (wordsLeft == 32'd1) begin
                            state <= bootPkg::finish;
                        end else begin
                            sdAddress <= sdAddress + 1'b1;
                            sdRead <= 1'b1;
                        end
                    end
                end
                bootPkg::finish: begin
                    ledOut <= 8'h00;
                    state <= bootPkg::running;
                end
                bootPkg::running: begin
                    if (cpuIoWrite.write) begin
                        ledOut <= cpuIoWrite.color;
                    end
                    if (pressed[0]) begin
                        debugAddress <= '0;
                        byteIndex <= '0;
                        state <= bootPkg::debug;
                    end
                end
                bootPkg::debug: begin
                    ledOut <= ramData[8 * byteIndex +: 8];
                    if (pressed[0]) begin
                        // Re-entering starts over at word 0
                        debugAddress <= '0;
                        byteIndex <= '0;
                    end else if (pressed[1]) begin
                        state <= bootPkg::running;
                    end else if (pressed[2]) begin
                        byteIndex <= byteIndex + 1'b1;
                        if (byteIndex == 2'd3) begin
                            debugAddress <= debugAddress + 1'b1;
                        end
                    end else if (pressed[3]) begin
                        byteIndex <= byteIndex - 1'b1;
                        if (byteIndex == 2'd0) begin
                            debugAddress <= debugAddress - 1'b1;
                        end
                    end
                end
                default: state <= bootPkg::resetWait;
            endcase
        end
    end

endmodule

// ==== design/busRouter.sv ====
module busRouter (
    input  logic                                 RAMClock,
    input  logic                                 reset,
    input  bootPkg::loaderState                  state,
    input  logic                                 loadWrite,
    input  logic [bootPkg::RamAddrBits-1:0]      loadAddress,
    input  logic [31:0]                          loadData,
    input  logic [bootPkg::RamAddrBits-1:0]      debugAddress,
    input  bootPkg::cpuBusReq                    cpuRequest,
    output bootPkg::cpuBusRsp                    cpuResponse,
    output bootPkg::ramReq                       ramRequest,
    input  logic                                 ramReady,
    input  logic                                 ramWritten,
    input  logic [31:0]                          ramData,
    output bootPkg::pixelWrite                   pixelOut
);

    logic cpuOwns;
    logic debugOwns;
    logic ioSelected;
    logic cpuRead;
    logic cpuWrite;
    logic ioReadPending;
    logic ramReadPending;
    logic ramWritePending;

    assign cpuOwns = (state == bootPkg::running);
    assign debugOwns = (state == bootPkg::debug);
    assign ioSelected = cpuRequest.address[bootPkg::ioSelectBit];

    // Read wins when the processor asserts both
    assign cpuRead = cpuOwns && cpuRequest.read;
    assign cpuWrite = cpuOwns && cpuRequest.write && !cpuRequest.read;

    always_comb begin
        if (cpuOwns) begin
            ramRequest.address = cpuRequest.address[bootPkg::RamAddrBits-1:0];
            ramRequest.writeData = cpuRequest.writeData;
            ramRequest.read = cpuRead && !ioSelected;
            ramRequest.write = cpuWrite && !ioSelected;
        end else if (debugOwns) begin
            ramRequest.address = debugAddress;
            ramRequest.writeData = '0;
            ramRequest.read = 1'b1;
            ramRequest.write = 1'b0;
        end else begin
            ramRequest.address = loadAddress;
            ramRequest.writeData = loadData;
            ramRequest.read = 1'b0;
            ramRequest.write = loadWrite;
        end
    end

    // Pixel coordinates come straight from the I/O address
    always_comb begin
        pixelOut.x = cpuRequest.address[15:8];
        pixelOut.y = cpuRequest.address[7:0];
        pixelOut.color = cpuRequest.writeData[7:0];
        pixelOut.write = cpuWrite && ioSelected;
    end

    // Track which processor access the next RAM strobe belongs to
    always_ff @(posedge RAMClock) begin
        if (reset) begin
            ioReadPending <= 1'b0;
            ramReadPending <= 1'b0;
            ramWritePending <= 1'b0;
        end else begin
            ioReadPending <= cpuRead && ioSelected;
            ramReadPending <= cpuRead && !ioSelected;
            ramWritePending <= cpuWrite && !ioSelected;
        end
    end

    always_comb begin
        cpuResponse.readData = ioReadPending ? 32'd0 : ramData;
        cpuResponse.ready = ioReadPending || (ramReadPending && ramReady);
        cpuResponse.written = pixelOut.write || (ramWritePending && ramWritten);
    end

endmodule

// ==== design/frameBuffer.sv ====
module frameBuffer (
    input  logic                 RAMClock,
    input  bootPkg::pixelWrite   pixelIn,
    input  logic [7:0]           readX,
    input  logic [7:0]           readY,
    output logic [7:0]           readColor
);

    // One byte per pixel, x selects the upper index half
    logic [7:0] pixels [256 * 256];

    always_ff @(posedge RAMClock) begin
        if (pixelIn.write) begin
            pixels[{pixelIn.x, pixelIn.y}] <= pixelIn.color;
        end
    end

    // Display side read, one cycle latency
    always_ff @(posedge RAMClock) begin
        readColor <= pixels[{readX, readY}];
    end

endmodule

// ==== design/bootSystem.sv ====
module bootSystem #(
    parameter int ResetCycles = 1023
) (
    input  logic                 RAMClock,
    input  logic                 reset,
    input  bootPkg::cpuBusReq    cpuRequest,
    output bootPkg::cpuBusRsp    cpuResponse,
    output logic                 cpuReset,
    output logic                 sdCs,
    output logic                 sdMosi,
    output logic                 sdClk,
    input  logic                 sdMiso,
    // Bit 0 debugEnter, bit 1 run, bit 2 next, bit 3 prev
    input  logic [3:0]           buttons,
    output logic [7:0]           ledOut,
    input  logic [7:0]           pixelX,
    input  logic [7:0]           pixelY,
    output logic [7:0]           pixelColor
);

    logic sdRead;
    logic [31:0] sdAddress;
    logic [31:0] sdData;
    logic sdBusy;
    logic sdDone;

    logic loadWrite;
    logic [bootPkg::RamAddrBits-1:0] loadAddress;
    logic [31:0] loadData;
    logic [bootPkg::RamAddrBits-1:0] debugAddress;
    bootPkg::loaderState state;

    bootPkg::ramReq ramRequest;
    logic [31:0] ramData;
    logic ramReady;
    logic ramWritten;
    bootPkg::pixelWrite pixelOut;

    bootLoader #(
        .ResetCycles(ResetCycles)
    ) loader_i (
        .RAMClock(RAMClock),
        .reset(reset),
        .buttons(buttons),
        .sdRead(sdRead),
        .sdAddress(sdAddress),
        .sdData(sdData),
        .sdBusy(sdBusy),
        .sdDone(sdDone),
        .loadWrite(loadWrite),
        .loadAddress(loadAddress),
        .loadData(loadData),
        .state(state),
        .debugAddress(debugAddress),
        .ramData(ramData),
        .cpuIoWrite(pixelOut),
        .cpuReset(cpuReset),
        .ledOut(ledOut)
    );

    sdWordReader reader_i (
        .RAMClock(RAMClock),
        .reset(reset),
        .read(sdRead),
        .address(sdAddress),
        .data(sdData),
        .busy(sdBusy),
        .done(sdDone),
        .cs(sdCs),
        .mosi(sdMosi),
        .sclk(sdClk),
        .miso(sdMiso)
    );

    busRouter router_i (
        .RAMClock(RAMClock),
        .reset(reset),
        .state(state),
        .loadWrite(loadWrite),
        .loadAddress(loadAddress),
        .loadData(loadData),
        .debugAddress(debugAddress),
        .cpuRequest(cpuRequest),
        .cpuResponse(cpuResponse),
        .ramRequest(ramRequest),
        .ramReady(ramReady),
        .ramWritten(ramWritten),
        .ramData(ramData),
        .pixelOut(pixelOut)
    );

    wordRam #(
        .Words(2 ** bootPkg::RamAddrBits)
    ) ram_i (
        .RAMClock(RAMClock),
        .request(ramRequest),
        .readData(ramData),
        .ready(ramReady),
        .written(ramWritten)
    );

    frameBuffer frame_i (
        .RAMClock(RAMClock),
        .pixelIn(pixelOut),
        .readX(pixelX),
        .readY(pixelY),
        .readColor(pixelColor)
    );

endmodule

// ==== bench/sdCardModel.sv ====
module sdCardModel #(
    parameter int Depth = 7
) (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);
    timeunit 1ns;
    timeprecision 100ps;

    // Filled by the testbench, word 0 holds the count
    logic [31:0] image [Depth];
    logic [31:0] command;
    logic [5:0] commandBits;
    logic [36:0] response;
    logic responding;

    initial begin
        miso = 1'b1;
        command = '0;
        commandBits = '0;
        responding = 1'b0;
    end

    // Command in on rising sclk, response out on falling sclk
    always @(sclk or cs) begin
        if (cs !== 1'b0) begin
            commandBits = '0;
            responding = 1'b0;
            miso = 1'b1;
        end else if (sclk === 1'b1) begin
            if (commandBits < 6'd32) begin
                command = {command[30:0], mosi};
                commandBits = commandBits + 1'b1;
            end
        end else begin
            // Only the single word read gets an answer
            if (commandBits == 6'd32 && !responding && command[31:24] == 8'h51) begin
                // Four busy bits, then the start bit and the word
                response = {4'b1111, 1'b0, image[command[23:0]]};
                responding = 1'b1;
            end
            if (responding) begin
                miso = response[36];
                response = {response[35:0], 1'b1};
            end
        end
    end

endmodule

// ==== bench/bootSystemTb.sv ====
module bootSystemTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TimeoutCycles = 20000;
    localparam int ImageWords = 6;

    typedef enum logic [2:0] {
        opRead,
        opWrite,
        opIoWrite,
        opPixel,
        opButton
    } opKind;

    // One table row, level is the expected cpuReset after a button
    typedef struct packed {
        opKind op;
        logic [31:0] address;
        logic [31:0] data;
        logic [31:0] expected;
        logic level;
    } stimRow;

    logic RAMClock;
    logic reset;
    bootPkg::cpuBusReq cpuRequest;
    bootPkg::cpuBusRsp cpuResponse;
    logic cpuReset;
    logic sdCs;
    logic sdMosi;
    logic sdClk;
    logic sdMiso;
    logic [3:0] buttons;
    logic [7:0] ledOut;
    logic [7:0] pixelX;
    logic [7:0] pixelY;
    logic [7:0] pixelColor;

    logic [31:0] imageWords [ImageWords + 1];
    logic [31:0] aliasValue;
    stimRow rows [$];
    string names [$];
    integer seed;
    int passCount;
    int failCount;
    bit testFailed;

    bootSystem #(
        .ResetCycles(20)
    ) dut_i (
        .RAMClock(RAMClock),
        .reset(reset),
        .cpuRequest(cpuRequest),
        .cpuResponse(cpuResponse),
        .cpuReset(cpuReset),
        .sdCs(sdCs),
        .sdMosi(sdMosi),
        .sdClk(sdClk),
        .sdMiso(sdMiso),
        .buttons(buttons),
        .ledOut(ledOut),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColor(pixelColor)
    );

    sdCardModel #(
        .Depth(ImageWords + 1)
    ) card_i (
        .cs(sdCs),
        .sclk(sdClk),
        .mosi(sdMosi),
        .miso(sdMiso)
    );

    always #20 RAMClock = ~RAMClock;

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input bootPkg::cpuBusRsp actual);
        if (actual.readData !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual.readData);
            testFailed = 1'b1;
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            testFailed = 1'b1;
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %b actual %b", name, expected, actual);
            testFailed = 1'b1;
        end
    endtask

    task automatic finishTest(input string name);
        if (testFailed) begin
            failCount++;
        end else begin
            passCount++;
            $display("pass %s", name);
        end
    endtask

    task automatic addRow(input string name, input opKind op, input logic [31:0] address,
                          input logic [31:0] data, input logic [31:0] expected,
                          input logic level);
        stimRow row;
        row.op = op;
        row.address = address;
        row.data = data;
        row.expected = expected;
        row.level = level;
        rows.push_back(row);
        names.push_back(name);
    endtask

    function automatic logic responseSeen(input stimRow row);
        case (row.op)
            opRead: responseSeen = cpuResponse.ready;
            opWrite, opIoWrite: responseSeen = cpuResponse.written;
            opButton: responseSeen = (ledOut === row.expected[7:0]) && (cpuReset === row.level);
            // Pixel read has a fixed latency of one cycle
            default: responseSeen = 1'b1;
        endcase
    endfunction

    // cpuReset must stay high while the LEDs show only loader patterns
    task automatic waitLoaded;
        int cycles;
        bit badLed;
        testFailed = 1'b0;
        cycles = 0;
        badLed = 1'b0;
        while (cpuReset === 1'b1 && cycles < TimeoutCycles) begin
            if (ledOut !== bootPkg::ledResetting && ledOut !== bootPkg::ledCounting &&
                ledOut !== bootPkg::ledLoading) begin
                badLed = 1'b1;
            end
            @(negedge RAMClock);
            cycles++;
        end
        if (cpuReset !== 1'b0) begin
            $display("timeout cpuReset did not fall within %0d cycles", TimeoutCycles);
            testFailed = 1'b1;
        end else if (badLed) begin
            $display("loading failed, ledOut left the loader patterns before cpuReset fell");
            testFailed = 1'b1;
        end
        finishTest("loading");
    endtask

    task automatic applyRow(input stimRow row, input string name);
        int cycles;
        testFailed = 1'b0;
        case (row.op)
            opRead, opWrite, opIoWrite: begin
                cpuRequest.address = row.address;
                cpuRequest.writeData = row.data;
                cpuRequest.read = (row.op == opRead);
                cpuRequest.write = (row.op != opRead);
            end
            opPixel: begin
                pixelX = row.address[15:8];
                pixelY = row.address[7:0];
            end
            default: buttons[row.data[1:0]] = 1'b1;
        endcase
        cycles = 0;
        // Request held until answered, buttons pulse for one cycle
        do begin
            @(negedge RAMClock);
            buttons = '0;
            cycles++;
        end while (!responseSeen(row) && cycles < TimeoutCycles);
        if (!responseSeen(row) && row.op != opButton) begin
            $display("timeout %s got no response within %0d cycles", name, TimeoutCycles);
            testFailed = 1'b1;
        end else begin
            case (row.op)
                opRead: checkWord(name, row.expected, cpuResponse);
                opIoWrite, opButton: checkByte(name, row.expected[7:0], ledOut);
                opPixel: checkByte(name, row.expected[7:0], pixelColor);
                default: ;
            endcase
            if (row.op == opButton) begin
                checkLevel(name, row.level, cpuReset);
            end
        end
        cpuRequest = '0;
        finishTest(name);
    endtask

    initial begin
        RAMClock = 1'b0;
        reset = 1'b1;
        cpuRequest = '0;
        buttons = '0;
        pixelX = '0;
        pixelY = '0;
        passCount = 0;
        failCount = 0;
        seed = 39287;
        imageWords[0] = ImageWords;
        for (int k = 1; k <= ImageWords; k++) begin
            imageWords[k] = $random(seed);
        end
        for (int k = 0; k <= ImageWords; k++) begin
            card_i.image[k] = imageWords[k];
        end
        aliasValue = $random(seed);

        // Card word k+1 sits in RAM word k
        for (int k = 0; k < ImageWords; k++) begin
            addRow($sformatf("read%0d", k), opRead, k, '0, imageWords[k + 1], 1'b0);
        end
        // RAM word 0x0C22 shares its low address bits with pixel (12,34)
        addRow("writeRam", opWrite, 32'h0000_0C22, aliasValue, '0, 1'b0);
        addRow("readBack", opRead, 32'h0000_0C22, '0, aliasValue, 1'b0);
        addRow("ioWrite", opIoWrite, 32'h8000_0C22, 32'h0000_00A5, 32'h0000_00A5, 1'b0);
        addRow("pixelRead", opPixel, {16'h0, 8'd12, 8'd34}, '0, 32'h0000_00A5, 1'b0);
        addRow("ramAfterIo", opRead, 32'h0000_0C22, '0, aliasValue, 1'b0);
        addRow("debugEnter", opButton, '0, 32'd0, imageWords[1][7:0], 1'b1);
        addRow("nextByte1", opButton, '0, 32'd2, imageWords[1][15:8], 1'b1);
        addRow("nextByte2", opButton, '0, 32'd2, imageWords[1][23:16], 1'b1);
        addRow("nextByte3", opButton, '0, 32'd2, imageWords[1][31:24], 1'b1);
        addRow("nextWord", opButton, '0, 32'd2, imageWords[2][7:0], 1'b1);
        addRow("runAgain", opButton, '0, 32'd1, imageWords[2][7:0], 1'b0);

        repeat (2) @(negedge RAMClock);
        reset = 1'b0;
        testFailed = 1'b0;
        checkLevel("afterReset", 1'b1, cpuReset);
        checkByte("afterReset", bootPkg::ledResetting, ledOut);
        finishTest("afterReset");

        waitLoaded();
        foreach (rows[i]) begin
            applyRow(rows[i], names[i]);
        end

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/bootPkg.sv
design/wordRam.sv
design/sdWordReader.sv
design/bootLoader.sv
design/busRouter.sv
design/frameBuffer.sv
design/bootSystem.sv
bench/sdCardModel.sv
bench/bootSystemTb.sv

// ==== Bender.yml ====
package:
  name: bootsystem

sources:
  - design/bootPkg.sv
  - design/wordRam.sv
  - design/sdWordReader.sv
  - design/bootLoader.sv
  - design/busRouter.sv
  - design/frameBuffer.sv
  - design/bootSystem.sv
  - target: test
    files:
      - bench/sdCardModel.sv
      - bench/bootSystemTb.sv
